/* hdl/cfg_macros.svh */
`ifndef CFG_MACROS_SVH
`define CFG_MACROS_SVH

// Identity and layout words
`define CFG_ADDR_FW_ID          16'h0000
`define CFG_ADDR_FW_VER         16'h0004
`define CFG_ADDR_BOARD_ID       16'h0008
`define CFG_ADDR_BOARD_VER      16'h000C
`define CFG_ADDR_IF_COUNT       16'h0020
`define CFG_ADDR_IF_STRIDE      16'h0024
`define CFG_ADDR_IF_CTRL_OFFSET 16'h002C
`define CFG_ADDR_FPGA_ID        16'h0040

`define CFG_ADDR_GPIO_I2C       16'h0110
`define CFG_ADDR_GPIO_XCVR      16'h0120

`define CFG_ADDR_DMA_EN         16'h0400
`define CFG_ADDR_CMD_DATA       16'h0404
`define CFG_ADDR_CMD            16'h0408
`define CFG_ADDR_LOOPBACK       16'h0480

// Descriptor windows, 32 bytes each
`define CFG_ADDR_RD_DESC_BASE   16'h0440
`define CFG_ADDR_WR_DESC_BASE   16'h0460
`define CFG_DESC_OFS_PCIE_LO    16'h0000
`define CFG_DESC_OFS_PCIE_HI    16'h0004
`define CFG_DESC_OFS_RAM        16'h0008
`define CFG_DESC_OFS_LEN        16'h0010
`define CFG_DESC_OFS_TAG        16'h0014
`define CFG_DESC_OFS_STAT       16'h0018

`define CFG_FW_ID               32'h0000_0000
`define CFG_FW_VER              32'h0000_0001
`define CFG_BOARD_ID            32'h1ce4_0003
`define CFG_BOARD_VER           32'h0000_0001
`define CFG_FPGA_ID             32'h0382_3093

`define CFG_IF_COUNT            32'd2
`define CFG_IF_STRIDE           32'h0100_0000
`define CFG_IF_CTRL_OFFSET      32'h0000_8000

`define CFG_CMD_FIFO_DEPTH      4

`endif

/* hdl/cfg_pkg.sv */
`default_nettype none

`include "cfg_macros.svh"

package cfg_pkg;

  typedef logic [15:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [3:0]  axil_strb_t;
  typedef logic [63:0] pcie_addr_t;
  typedef logic [31:0] ram_addr_t;
  typedef logic [15:0] dma_len_t;
  typedef logic [31:0] dma_tag_t;  // also the status bitmap
  typedef logic [31:0] host_cmd_t;

  // Accepted AXI-lite write
  typedef struct packed {
    logic       stb;
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
  } reg_wr_t;

  typedef struct packed {
    pcie_addr_t pcie_addr;
    ram_addr_t  ram_addr;
    dma_len_t   len;
    dma_tag_t   tag;
  } dma_desc_t;

  typedef struct packed {
    logic     valid;
    dma_tag_t tag;
  } dma_status_t;

  typedef struct packed {
    logic modprsl;
    logic intl;
  } qsfp_in_t;

  typedef struct packed {
    logic resetl;
    logic lpmode;
  } qsfp_out_t;

  typedef struct packed {
    logic          scl;
    logic          sda;
    qsfp_in_t [1:0] qsfp;
  } gpio_in_t;

  typedef struct packed {
    logic           scl_o;
    logic           sda_o;
    qsfp_out_t [1:0] qsfp;
  } gpio_out_t;

  // Bus released, modules out of reset, full power
  localparam gpio_out_t GPIO_OUT_RST = '{scl_o: 1'b1, sda_o: 1'b1, qsfp: {2{2'b10}}};
  localparam gpio_in_t  GPIO_IN_RST  = '{scl: 1'b1, sda: 1'b1, qsfp: '0};

endpackage

`default_nettype wire

/* hdl/cfg_axil_slave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_macros.svh"

module cfg_axil_slave
  import cfg_pkg::*;
(
  input  wire             pcie_clk,
  input  wire             pcie_rst,

  input  wire axil_addr_t s_axil_awaddr_i,
  input  wire             s_axil_awvalid_i,
  output logic            s_axil_awready_o,
  input  wire axil_data_t s_axil_wdata_i,
  input  wire axil_strb_t s_axil_wstrb_i,
  input  wire             s_axil_wvalid_i,
  output logic            s_axil_wready_o,
  output logic [1:0]      s_axil_bresp_o,
  output logic            s_axil_bvalid_o,
  input  wire             s_axil_bready_i,
  input  wire axil_addr_t s_axil_araddr_i,
  input  wire             s_axil_arvalid_i,
  output logic            s_axil_arready_o,
  output axil_data_t      s_axil_rdata_o,
  output logic [1:0]      s_axil_rresp_o,
  output logic            s_axil_rvalid_o,
  input  wire             s_axil_rready_i,

  output reg_wr_t         rd_wr_o,
  output reg_wr_t         wr_wr_o,
  output logic            rd_stat_clr_o,
  output logic            wr_stat_clr_o,
  input  wire dma_tag_t   rd_stat_i,
  input  wire dma_tag_t   wr_stat_i,

  output gpio_out_t       gpio_out_o,
  input  wire gpio_out_t  gpio_out_fb_i,
  input  wire gpio_in_t   gpio_in_i,

  output host_cmd_t       cmd_o,
  output logic            cmd_push_o,
  input  wire             cmd_ready_i,
  output host_cmd_t       cmd_wr_data_o,
  input  wire host_cmd_t  cmd_rd_data_i,

  output logic            pcie_dma_enable_o,
  output logic            loopback_o
);

  localparam axil_addr_t RD_BASE = `CFG_ADDR_RD_DESC_BASE;
  localparam axil_addr_t WR_BASE = `CFG_ADDR_WR_DESC_BASE;
  localparam axil_addr_t RD_STAT = RD_BASE + `CFG_DESC_OFS_STAT;
  localparam axil_addr_t WR_STAT = WR_BASE + `CFG_DESC_OFS_STAT;

  logic       wr_take;
  logic       rd_take;
  axil_addr_t wr_addr;
  axil_addr_t rd_addr;
  host_cmd_t  cmd_rd_q;
  axil_data_t gpio_i2c_word;
  axil_data_t gpio_xcvr_word;

  assign wr_take = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
  assign rd_take = s_axil_arvalid_i && !s_axil_rvalid_o;
  assign wr_addr = {s_axil_awaddr_i[15:2], 2'b00};
  assign rd_addr = {s_axil_araddr_i[15:2], 2'b00};

  assign s_axil_bresp_o = 2'b00;  // always OKAY
  assign s_axil_rresp_o = 2'b00;

  // Channel gets its own strobe and the byte offset inside its window
  assign rd_wr_o = '{stb: wr_take && (wr_addr[15:5] == RD_BASE[15:5]),
                     addr: axil_addr_t'(wr_addr[4:0]),
                     data: s_axil_wdata_i, strb: s_axil_wstrb_i};
  assign wr_wr_o = '{stb: wr_take && (wr_addr[15:5] == WR_BASE[15:5]),
                     addr: axil_addr_t'(wr_addr[4:0]),
                     data: s_axil_wdata_i, strb: s_axil_wstrb_i};

  assign rd_stat_clr_o = rd_take && (rd_addr == RD_STAT);
  assign wr_stat_clr_o = rd_take && (rd_addr == WR_STAT);

  always_comb begin
    gpio_i2c_word    = '0;
    gpio_i2c_word[0] = gpio_in_i.scl;
    gpio_i2c_word[1] = gpio_out_fb_i.scl_o;
    gpio_i2c_word[8] = gpio_in_i.sda;
    gpio_i2c_word[9] = gpio_out_fb_i.sda_o;
    gpio_xcvr_word   = '0;
    // Active-low pins shown inverted
    for (int i = 0; i < 2; i++) begin
      gpio_xcvr_word[8*i]   = !gpio_in_i.qsfp[i].modprsl;
      gpio_xcvr_word[8*i+1] = !gpio_in_i.qsfp[i].intl;
      gpio_xcvr_word[8*i+4] = !gpio_out_fb_i.qsfp[i].resetl;
      gpio_xcvr_word[8*i+5] = gpio_out_fb_i.qsfp[i].lpmode;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      s_axil_awready_o  <= 1'b0;
      s_axil_wready_o   <= 1'b0;
      s_axil_bvalid_o   <= 1'b0;
      s_axil_arready_o  <= 1'b0;
      s_axil_rvalid_o   <= 1'b0;
      cmd_push_o        <= 1'b0;
      pcie_dma_enable_o <= 1'b1;
      loopback_o        <= 1'b0;
      gpio_out_o        <= GPIO_OUT_RST;
    end else begin
      s_axil_awready_o <= wr_take;
      s_axil_wready_o  <= wr_take;
      s_axil_bvalid_o  <= wr_take || (s_axil_bvalid_o && !s_axil_bready_i);
      s_axil_arready_o <= rd_take;
      s_axil_rvalid_o  <= rd_take || (s_axil_rvalid_o && !s_axil_rready_i);
      cmd_push_o       <= cmd_push_o && !cmd_ready_i;  // hold while FIFO full

      if (wr_take) begin
        case (wr_addr)
          `CFG_ADDR_GPIO_I2C: begin
            if (s_axil_wstrb_i[0]) gpio_out_o.scl_o <= s_axil_wdata_i[1];
            if (s_axil_wstrb_i[1]) gpio_out_o.sda_o <= s_axil_wdata_i[9];
          end
          `CFG_ADDR_GPIO_XCVR: begin
            for (int i = 0; i < 2; i++) begin
              if (s_axil_wstrb_i[i]) begin
                gpio_out_o.qsfp[i].resetl <= !s_axil_wdata_i[8*i+4];
                gpio_out_o.qsfp[i].lpmode <= s_axil_wdata_i[8*i+5];
              end
            end
          end
          `CFG_ADDR_DMA_EN:   pcie_dma_enable_o <= s_axil_wdata_i[0];
          `CFG_ADDR_CMD:      cmd_push_o        <= 1'b1;
          `CFG_ADDR_LOOPBACK: loopback_o        <= s_axil_wdata_i[0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge pcie_clk) begin
    cmd_rd_q <= cmd_rd_data_i;
    if (wr_take && wr_addr == `CFG_ADDR_CMD_DATA) cmd_wr_data_o <= s_axil_wdata_i;
    if (wr_take && wr_addr == `CFG_ADDR_CMD) cmd_o <= s_axil_wdata_i;  // overwrites pending

    if (rd_take) begin
      case (rd_addr)
        `CFG_ADDR_FW_ID:          s_axil_rdata_o <= `CFG_FW_ID;
        `CFG_ADDR_FW_VER:         s_axil_rdata_o <= `CFG_FW_VER;
        `CFG_ADDR_BOARD_ID:       s_axil_rdata_o <= `CFG_BOARD_ID;
        `CFG_ADDR_BOARD_VER:      s_axil_rdata_o <= `CFG_BOARD_VER;
        `CFG_ADDR_IF_COUNT:       s_axil_rdata_o <= `CFG_IF_COUNT;
        `CFG_ADDR_IF_STRIDE:      s_axil_rdata_o <= `CFG_IF_STRIDE;
        `CFG_ADDR_IF_CTRL_OFFSET: s_axil_rdata_o <= `CFG_IF_CTRL_OFFSET;
        `CFG_ADDR_FPGA_ID:        s_axil_rdata_o <= `CFG_FPGA_ID;
        `CFG_ADDR_GPIO_I2C:       s_axil_rdata_o <= gpio_i2c_word;
        `CFG_ADDR_GPIO_XCVR:      s_axil_rdata_o <= gpio_xcvr_word;
        `CFG_ADDR_DMA_EN:         s_axil_rdata_o <= axil_data_t'(pcie_dma_enable_o);
        `CFG_ADDR_CMD_DATA:       s_axil_rdata_o <= cmd_rd_q;
        `CFG_ADDR_LOOPBACK:       s_axil_rdata_o <= axil_data_t'(loopback_o);
        RD_STAT:                  s_axil_rdata_o <= rd_stat_i;  // value before clear
        WR_STAT:                  s_axil_rdata_o <= wr_stat_i;
        default:                  s_axil_rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/dma_desc_channel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_macros.svh"

module dma_desc_channel
  import cfg_pkg::*;
(
  input  wire              pcie_clk,
  input  wire              pcie_rst,
  input  wire reg_wr_t     reg_wr_i,
  input  wire              stat_clr_i,
  output dma_desc_t        desc_o,
  output logic             desc_valid_o,
  input  wire              desc_ready_i,
  input  wire dma_status_t status_i,
  output dma_tag_t         stat_o
);

  // Byte lanes of new_word replace old_word where strb is set
  function automatic axil_data_t merge_bytes(axil_data_t old_word, axil_data_t new_word,
                                             axil_strb_t strb);
    axil_data_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  always_ff @(posedge pcie_clk) begin
    if (reg_wr_i.stb) begin
      case (reg_wr_i.addr)
        `CFG_DESC_OFS_PCIE_LO: desc_o.pcie_addr[31:0] <=
          merge_bytes(desc_o.pcie_addr[31:0], reg_wr_i.data, reg_wr_i.strb);
        `CFG_DESC_OFS_PCIE_HI: desc_o.pcie_addr[63:32] <=
          merge_bytes(desc_o.pcie_addr[63:32], reg_wr_i.data, reg_wr_i.strb);
        `CFG_DESC_OFS_RAM: desc_o.ram_addr <=
          merge_bytes(desc_o.ram_addr, reg_wr_i.data, reg_wr_i.strb);
        `CFG_DESC_OFS_LEN: desc_o.len <=
          dma_len_t'(merge_bytes(axil_data_t'(desc_o.len), reg_wr_i.data, reg_wr_i.strb));
        `CFG_DESC_OFS_TAG: desc_o.tag <=
          merge_bytes(desc_o.tag, reg_wr_i.data, reg_wr_i.strb);
        default: ;
      endcase
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      desc_valid_o <= 1'b0;
      stat_o       <= '0;
    end else begin
      // Tag write launches the descriptor, even on top of a pending one
      if (reg_wr_i.stb && reg_wr_i.addr == `CFG_DESC_OFS_TAG) desc_valid_o <= 1'b1;
      else desc_valid_o <= desc_valid_o && !desc_ready_i;

      if (stat_clr_i) stat_o <= status_i.valid ? status_i.tag : '0;
      else if (status_i.valid) stat_o <= stat_o | status_i.tag;
    end
  end

endmodule

`default_nettype wire

/* hdl/gpio_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_sync
  import cfg_pkg::*;
(
  input  wire            pcie_clk,
  input  wire            pcie_rst,
  input  wire gpio_in_t  pins_i,
  output gpio_in_t       pins_sync_o,
  input  wire gpio_out_t out_i,
  output gpio_out_t      out_stage_o,
  output gpio_out_t      pins_o,
  output logic           scl_t_o,
  output logic           sda_t_o
);

  gpio_in_t sync_q;  // first synchronizer stage

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      sync_q      <= GPIO_IN_RST;
      pins_sync_o <= GPIO_IN_RST;
    end else begin
      sync_q      <= pins_i;
      pins_sync_o <= sync_q;
    end
  end

  // Two registers between the control register and the pads
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      out_stage_o <= GPIO_OUT_RST;
      pins_o      <= GPIO_OUT_RST;
      scl_t_o     <= 1'b1;
      sda_t_o     <= 1'b1;
    end else begin
      out_stage_o <= out_i;
      pins_o      <= out_stage_o;
      // Open drain, tristate whenever the line is driven high
      scl_t_o     <= out_stage_o.scl_o;
      sda_t_o     <= out_stage_o.sda_o;
    end
  end

endmodule

`default_nettype wire

/* hdl/host_cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_macros.svh"

module host_cmd_fifo
  import cfg_pkg::*;
#(
  parameter int DEPTH = `CFG_CMD_FIFO_DEPTH
) (
  input  wire            pcie_clk,
  input  wire            pcie_rst,
  input  wire            push_i,
  input  wire host_cmd_t data_i,
  output logic           ready_o,
  output host_cmd_t      data_o,
  output logic           valid_o
);

  localparam int AW = $clog2(DEPTH);

  host_cmd_t     mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          empty;
  logic          bypass;
  logic          store;

  assign empty   = (count == '0);
  assign ready_o = (count != (AW+1)'(DEPTH));
  assign bypass  = push_i && empty;  // straight into the output register
  assign store   = push_i && ready_o && !empty;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= !empty || bypass;  // consumer always ready
      if (store) wr_ptr <= wr_ptr + 1'b1;
      if (!empty) rd_ptr <= rd_ptr + 1'b1;
      count <= count + {{AW{1'b0}}, store} - {{AW{1'b0}}, !empty};
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (store) mem[wr_ptr] <= data_i;
    if (!empty) data_o <= mem[rd_ptr];
    else if (bypass) data_o <= data_i;
  end

endmodule

`default_nettype wire

/* hdl/pcie_config_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pcie_config_top
  import cfg_pkg::*;
(
  input  wire              pcie_clk,
  input  wire              pcie_rst,

  input  wire axil_addr_t  s_axil_awaddr_i,
  input  wire              s_axil_awvalid_i,
  output logic             s_axil_awready_o,
  input  wire axil_data_t  s_axil_wdata_i,
  input  wire axil_strb_t  s_axil_wstrb_i,
  input  wire              s_axil_wvalid_i,
  output logic             s_axil_wready_o,
  output logic [1:0]       s_axil_bresp_o,
  output logic             s_axil_bvalid_o,
  input  wire              s_axil_bready_i,
  input  wire axil_addr_t  s_axil_araddr_i,
  input  wire              s_axil_arvalid_i,
  output logic             s_axil_arready_o,
  output axil_data_t       s_axil_rdata_o,
  output logic [1:0]       s_axil_rresp_o,
  output logic             s_axil_rvalid_o,
  input  wire              s_axil_rready_i,

  output dma_desc_t        rd_desc_o,
  output logic             rd_desc_valid_o,
  input  wire              rd_desc_ready_i,
  input  wire dma_status_t rd_status_i,
  output dma_desc_t        wr_desc_o,
  output logic             wr_desc_valid_o,
  input  wire              wr_desc_ready_i,
  input  wire dma_status_t wr_status_i,

  input  wire gpio_in_t    gpio_i,
  output gpio_out_t        gpio_o,
  output logic             gpio_scl_t_o,
  output logic             gpio_sda_t_o,

  output host_cmd_t        host_cmd_o,
  output logic             host_cmd_valid_o,
  output host_cmd_t        host_cmd_wr_data_o,
  input  wire host_cmd_t   host_cmd_rd_data_i,

  output logic             pcie_dma_enable_o,
  output logic             loopback_o
);

  reg_wr_t   rd_wr;
  reg_wr_t   wr_wr;
  logic      rd_stat_clr;
  logic      wr_stat_clr;
  dma_tag_t  rd_stat;
  dma_tag_t  wr_stat;
  gpio_out_t gpio_out;
  gpio_out_t gpio_out_fb;
  gpio_in_t  gpio_in_sync;
  host_cmd_t cmd;
  logic      cmd_push;
  logic      cmd_ready;

  cfg_axil_slave u_slave (
    .pcie_clk, .pcie_rst,
    .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o,
    .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
    .s_axil_bresp_o, .s_axil_bvalid_o, .s_axil_bready_i,
    .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o,
    .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rvalid_o, .s_axil_rready_i,
    .rd_wr_o(rd_wr), .wr_wr_o(wr_wr),
    .rd_stat_clr_o(rd_stat_clr), .wr_stat_clr_o(wr_stat_clr),
    .rd_stat_i(rd_stat), .wr_stat_i(wr_stat),
    .gpio_out_o(gpio_out), .gpio_out_fb_i(gpio_out_fb), .gpio_in_i(gpio_in_sync),
    .cmd_o(cmd), .cmd_push_o(cmd_push), .cmd_ready_i(cmd_ready),
    .cmd_wr_data_o(host_cmd_wr_data_o), .cmd_rd_data_i(host_cmd_rd_data_i),
    .pcie_dma_enable_o, .loopback_o
  );

  dma_desc_channel u_rd_desc (
    .pcie_clk, .pcie_rst,
    .reg_wr_i(rd_wr), .stat_clr_i(rd_stat_clr),
    .desc_o(rd_desc_o), .desc_valid_o(rd_desc_valid_o), .desc_ready_i(rd_desc_ready_i),
    .status_i(rd_status_i), .stat_o(rd_stat)
  );

  dma_desc_channel u_wr_desc (
    .pcie_clk, .pcie_rst,
    .reg_wr_i(wr_wr), .stat_clr_i(wr_stat_clr),
    .desc_o(wr_desc_o), .desc_valid_o(wr_desc_valid_o), .desc_ready_i(wr_desc_ready_i),
    .status_i(wr_status_i), .stat_o(wr_stat)
  );

  gpio_sync u_gpio (
    .pcie_clk, .pcie_rst,
    .pins_i(gpio_i), .pins_sync_o(gpio_in_sync),
    .out_i(gpio_out), .out_stage_o(gpio_out_fb),
    .pins_o(gpio_o), .scl_t_o(gpio_scl_t_o), .sda_t_o(gpio_sda_t_o)
  );

  host_cmd_fifo u_cmd_fifo (
    .pcie_clk, .pcie_rst,
    .push_i(cmd_push), .data_i(cmd), .ready_o(cmd_ready),
    .data_o(host_cmd_o), .valid_o(host_cmd_valid_o)
  );

endmodule

`default_nettype wire

/* dv/pcie_config_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module pcie_config_checker (
  input wire pcie_clk,
  input wire pcie_rst,
  input wire bvalid_i,
  input wire bready_i,
  input wire rvalid_i,
  input wire rready_i,
  input wire awready_i,
  input wire desc_valid_i,
  input wire desc_ready_i
);

  bvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  desc_valid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    desc_valid_i && !desc_ready_i |=> desc_valid_i)
    else $error("descriptor valid dropped before ready");

  // Address accept goes with a fresh write response
  awready_pulse: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    awready_i |-> $rose(bvalid_i))
    else $error("awready seen without a new write response");

endmodule

bind cfg_axil_slave pcie_config_checker u_axil_chk (
  .pcie_clk, .pcie_rst,
  .bvalid_i(s_axil_bvalid_o), .bready_i(s_axil_bready_i),
  .rvalid_i(s_axil_rvalid_o), .rready_i(s_axil_rready_i),
  .awready_i(s_axil_awready_o),
  .desc_valid_i(1'b0), .desc_ready_i(1'b0)
);

bind dma_desc_channel pcie_config_checker u_desc_chk (
  .pcie_clk, .pcie_rst,
  .bvalid_i(1'b0), .bready_i(1'b0), .rvalid_i(1'b0), .rready_i(1'b0), .awready_i(1'b0),
  .desc_valid_i(desc_valid_o), .desc_ready_i(desc_ready_i)
);

`default_nettype wire

/* dv/pcie_config_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_macros.svh"

module pcie_config_tb
  import cfg_pkg::*;
();

  localparam int TIMEOUT = 50;  // cycles per wait

  logic        pcie_clk;
  logic        pcie_rst;
  axil_addr_t  awaddr;
  logic        awvalid;
  axil_data_t  wdata;
  axil_strb_t  wstrb;
  logic        wvalid;
  logic        bready;
  axil_addr_t  araddr;
  logic        arvalid;
  logic        rready;
  logic        awready;
  logic        wready;
  logic        bvalid;
  logic        arready;
  logic        rvalid;
  logic [1:0]  bresp;
  logic [1:0]  rresp;
  axil_data_t  rdata;
  dma_desc_t   desc [2];
  logic        desc_valid [2];
  logic        desc_ready [2];
  dma_status_t status [2];
  gpio_in_t    gpio_in;
  gpio_out_t   gpio_out;
  logic        scl_t;
  logic        sda_t;
  host_cmd_t   host_cmd;
  host_cmd_t   host_cmd_wr_data;
  host_cmd_t   host_cmd_rd_data;
  logic        host_cmd_valid;
  logic        dma_enable;
  logic        loopback;

  string       test_name;
  logic [31:0] rng_state;
  host_cmd_t   cmd_seen [$];

  pcie_config_top i_dut (
    .pcie_clk, .pcie_rst,
    .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
    .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
    .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
    .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
    .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
    .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready),
    .rd_desc_o(desc[0]), .rd_desc_valid_o(desc_valid[0]), .rd_desc_ready_i(desc_ready[0]),
    .rd_status_i(status[0]),
    .wr_desc_o(desc[1]), .wr_desc_valid_o(desc_valid[1]), .wr_desc_ready_i(desc_ready[1]),
    .wr_status_i(status[1]),
    .gpio_i(gpio_in), .gpio_o(gpio_out), .gpio_scl_t_o(scl_t), .gpio_sda_t_o(sda_t),
    .host_cmd_o(host_cmd), .host_cmd_valid_o(host_cmd_valid),
    .host_cmd_wr_data_o(host_cmd_wr_data), .host_cmd_rd_data_i(host_cmd_rd_data),
    .pcie_dma_enable_o(dma_enable), .loopback_o(loopback)
  );

  initial begin
    pcie_clk = 1'b0;
    forever #50 pcie_clk = ~pcie_clk;
  end

  // Always-ready command consumer
  always @(negedge pcie_clk) begin
    if (host_cmd_valid) cmd_seen.push_back(host_cmd);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic stop_sim(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped in test %s", test_name);
  endtask

  task automatic check_data(input axil_data_t exp, input axil_data_t act);
    if (act !== exp) stop_sim($sformatf("FAIL %s: expected %h actual %h", test_name, exp, act));
  endtask

  task automatic check_desc(input dma_desc_t exp, input dma_desc_t act);
    if (act !== exp) stop_sim($sformatf("FAIL %s: expected %h actual %h", test_name, exp, act));
  endtask

  task automatic check_cmd(input host_cmd_t exp, input host_cmd_t act);
    if (act !== exp) stop_sim($sformatf("FAIL %s: expected %h actual %h", test_name, exp, act));
  endtask

  task automatic check_resp(input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) stop_sim($sformatf("FAIL %s: expected %b actual %b", test_name, exp, act));
  endtask

  task automatic check_level(input logic exp, input logic act);
    if (act !== exp) stop_sim($sformatf("FAIL %s: expected %b actual %b", test_name, exp, act));
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input int stall = 0);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (stall == 0);
    n = 0;
    do begin
      @(posedge pcie_clk);
      #1;
      n++;
      if (n > TIMEOUT) stop_sim("Timeout: no write response on the AXI-lite bus");
    end while (!bvalid);
    check_level(1'b1, awready);
    check_level(1'b1, wready);
    check_resp(2'b00, bresp);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat (stall) begin
      @(posedge pcie_clk);
      #1;
      check_level(1'b1, bvalid);  // held until bready
    end
    if (stall > 0) begin
      bready = 1'b1;
      @(posedge pcie_clk);
      #1;
      check_level(1'b0, bvalid);
    end
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           input int stall = 0);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = (stall == 0);
    n = 0;
    do begin
      @(posedge pcie_clk);
      #1;
      n++;
      if (n > TIMEOUT) stop_sim("Timeout: no read data on the AXI-lite bus");
    end while (!rvalid);
    check_level(1'b1, arready);
    check_resp(2'b00, rresp);
    arvalid = 1'b0;
    repeat (stall) begin
      @(posedge pcie_clk);
      #1;
      check_level(1'b1, rvalid);  // held until rready
    end
    data = rdata;
    if (stall > 0) begin
      rready = 1'b1;
      @(posedge pcie_clk);
      #1;
      check_level(1'b0, rvalid);
    end
  endtask

  task automatic read_check(input axil_addr_t addr, input axil_data_t exp,
                            input int stall = 0);
    axil_data_t d;
    axil_read(addr, d, stall);
    check_data(exp, d);
  endtask

  task automatic send_status(input int ch, input dma_tag_t t);
    status[ch] = '{valid: 1'b1, tag: t};
    @(posedge pcie_clk);
    #1;
    status[ch] = '0;
  endtask

  task automatic test_identity();
    test_name = "identity";
    read_check(`CFG_ADDR_FW_ID, `CFG_FW_ID);
    read_check(`CFG_ADDR_FW_VER, `CFG_FW_VER);
    read_check(`CFG_ADDR_BOARD_ID, `CFG_BOARD_ID);
    read_check(`CFG_ADDR_BOARD_VER, `CFG_BOARD_VER);
    read_check(`CFG_ADDR_FPGA_ID, `CFG_FPGA_ID);
    read_check(`CFG_ADDR_IF_COUNT, `CFG_IF_COUNT);
    read_check(`CFG_ADDR_IF_STRIDE, `CFG_IF_STRIDE);
    read_check(`CFG_ADDR_IF_CTRL_OFFSET, `CFG_IF_CTRL_OFFSET);
    read_check(`CFG_ADDR_DMA_EN, 32'h1);
    read_check(`CFG_ADDR_LOOPBACK, 32'h0);
    read_check(16'h0200, 32'h0);  // Hole in the map
  endtask

  task automatic test_desc();
    dma_desc_t  exp;
    axil_addr_t base;
    int         n;
    test_name = "descriptor";
    for (int ch = 0; ch < 2; ch++) begin
      base = (ch == 0) ? `CFG_ADDR_RD_DESC_BASE : `CFG_ADDR_WR_DESC_BASE;
      exp.pcie_addr = {next_rand(), next_rand()};
      exp.ram_addr  = next_rand();
      exp.len       = dma_len_t'(next_rand());
      exp.tag       = next_rand();
      axil_write(base + `CFG_DESC_OFS_PCIE_LO, exp.pcie_addr[31:0], 4'hf);
      axil_write(base + `CFG_DESC_OFS_PCIE_HI, exp.pcie_addr[63:32], 4'hf);
      axil_write(base + `CFG_DESC_OFS_RAM, exp.ram_addr, 4'hf);
      axil_write(base + `CFG_DESC_OFS_LEN, {16'h0, exp.len}, 4'hf);
      axil_write(base + `CFG_DESC_OFS_TAG, exp.tag, 4'hf);
      n = 0;
      while (!desc_valid[ch]) begin
        @(posedge pcie_clk);
        #1;
        n++;
        if (n > TIMEOUT) stop_sim("Timeout: descriptor valid never rose");
      end
      check_desc(exp, desc[ch]);
      repeat (4) begin
        @(posedge pcie_clk);
        #1;
        check_level(1'b1, desc_valid[ch]);  // held without ready
      end
      desc_ready[ch] = 1'b1;
      @(posedge pcie_clk);
      #1;
      desc_ready[ch] = 1'b0;
      check_level(1'b0, desc_valid[ch]);
    end
  endtask

  task automatic test_status();
    axil_addr_t addr;
    dma_tag_t   acc;
    dma_tag_t   t;
    test_name = "status";
    for (int ch = 0; ch < 2; ch++) begin
      addr = ((ch == 0) ? `CFG_ADDR_RD_DESC_BASE : `CFG_ADDR_WR_DESC_BASE) + `CFG_DESC_OFS_STAT;
      acc = '0;
      for (int i = 0; i < 3; i++) begin
        t = next_rand();
        acc = acc | t;
        send_status(ch, t);
      end
      read_check(addr, acc);
      read_check(addr, 32'h0);
      t = next_rand();
      send_status(ch, t);
      // New tag lands in the same cycle the read is taken
      acc = next_rand();
      status[ch] = '{valid: 1'b1, tag: acc};
      read_check(addr, t);
      status[ch] = '0;
      read_check(addr, acc);
      read_check(addr, 32'h0);
    end
  endtask

  task automatic test_gpio();
    gpio_out_t exp;
    int        n;
    test_name = "gpio";
    exp.scl_o          = 1'b0;
    exp.sda_o          = 1'b0;
    exp.qsfp[0].resetl = 1'b0;
    exp.qsfp[0].lpmode = 1'b0;
    exp.qsfp[1].resetl = 1'b1;
    exp.qsfp[1].lpmode = 1'b1;
    axil_write(`CFG_ADDR_GPIO_I2C, 32'h0, 4'h3);
    axil_write(`CFG_ADDR_GPIO_XCVR, 32'h0000_2010, 4'h3);  // Cage 0 in reset and cage 1 low power
    n = 0;
    while (gpio_out !== exp) begin
      @(posedge pcie_clk);
      #1;
      n++;
      if (n > TIMEOUT) stop_sim("Timeout: GPIO outputs did not follow the register");
    end
    check_level(exp.scl_o, scl_t);
    check_level(exp.sda_o, sda_t);
    gpio_in.scl             = 1'b0;
    gpio_in.sda             = 1'b1;
    gpio_in.qsfp[0].modprsl = 1'b0;
    gpio_in.qsfp[0].intl    = 1'b1;
    gpio_in.qsfp[1].modprsl = 1'b1;
    gpio_in.qsfp[1].intl    = 1'b0;
    repeat (3) @(posedge pcie_clk);
    #1;
    read_check(`CFG_ADDR_GPIO_I2C, 32'h0000_0100);   // Only SDA in is high
    read_check(`CFG_ADDR_GPIO_XCVR, 32'h0000_2211);
  endtask

  task automatic test_host_cmd();
    host_cmd_t words [3];
    host_cmd_t d;
    int        n;
    test_name = "host command";
    d = next_rand();
    axil_write(`CFG_ADDR_CMD_DATA, d, 4'hf);
    check_cmd(d, host_cmd_wr_data);
    cmd_seen.delete();
    foreach (words[i]) begin
      words[i] = next_rand();
      axil_write(`CFG_ADDR_CMD, words[i], 4'hf);
    end
    n = 0;
    while (cmd_seen.size() < 3) begin
      @(posedge pcie_clk);
      #1;
      n++;
      if (n > TIMEOUT) stop_sim("Timeout: host command words did not come out");
    end
    repeat (4) @(posedge pcie_clk);
    #1;
    if (cmd_seen.size() != 3) stop_sim("Extra host command valid pulses were seen");
    foreach (words[i]) check_cmd(words[i], cmd_seen[i]);
    host_cmd_rd_data = next_rand();
    @(posedge pcie_clk);
    #1;
    read_check(`CFG_ADDR_CMD_DATA, host_cmd_rd_data);
  endtask

  task automatic test_control();
    test_name = "control";
    axil_write(`CFG_ADDR_DMA_EN, 32'h0, 4'hf);
    check_level(1'b0, dma_enable);
    read_check(`CFG_ADDR_DMA_EN, 32'h0);
    axil_write(`CFG_ADDR_LOOPBACK, 32'h1, 4'hf, 3);  // Master stalls the response
    check_level(1'b1, loopback);
    read_check(`CFG_ADDR_LOOPBACK, 32'h1, 3);
  endtask

  initial begin
    rng_state        = 32'h0b80_977f;
    test_name        = "reset";
    pcie_rst         = 1'b1;
    awaddr           = '0;
    awvalid          = 1'b0;
    wdata            = '0;
    wstrb            = '0;
    wvalid           = 1'b0;
    bready           = 1'b1;
    araddr           = '0;
    arvalid          = 1'b0;
    rready           = 1'b1;
    desc_ready[0]    = 1'b0;
    desc_ready[1]    = 1'b0;
    status[0]        = '0;
    status[1]        = '0;
    gpio_in          = '1;
    host_cmd_rd_data = '0;
    repeat (2) @(posedge pcie_clk);
    #1;
    pcie_rst = 1'b0;

    test_identity();
    test_desc();
    test_status();
    test_gpio();
    test_host_cmd();
    test_control();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/cfg_pkg.sv
hdl/cfg_axil_slave.sv
hdl/dma_desc_channel.sv
hdl/gpio_sync.sv
hdl/host_cmd_fifo.sv
hdl/pcie_config_top.sv
dv/pcie_config_checker.sv
dv/pcie_config_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module pcie_config_tb -o pcie_config_sim

./obj_dir/pcie_config_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
